// ==== axis_pkg.sv ====
// stream beat layout and ingress FIFO sizing
// fifo_addr_width must equal log2 of fifo_depth

package axis_pkg;

   localparam int data_width = 64;
   localparam int strb_width = data_width / 8;
   localparam int user_width = 32;

   // ingress buffer
   localparam int fifo_depth      = 16;
   localparam int fifo_addr_width = 4;
   localparam int fifo_slack      = 2;   // free entries left when tready drops

   // one AXI-Stream beat, 105 bits
   typedef struct packed {
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
      logic [user_width-1:0] user;
      logic                  last;
   } axis_beat_t;

endpackage

// ==== ualink_pkg.sv ====
// command format and buffer memory types for the packet engine
// a command covers at most burst_len data beats after the header

package ualink_pkg;

   localparam int mem_addr_width = 8;
   localparam int mem_depth      = 1 << mem_addr_width;
   localparam int burst_len      = 8;

   localparam logic [15:0] op_write = 16'h0245;
   localparam logic [15:0] op_read  = 16'h0145;

   typedef logic [mem_addr_width-1:0]        mem_addr_t;
   typedef logic [axis_pkg::data_width-1:0]  mem_word_t;

   // beat index within a packet, saturates one past the burst
   typedef logic [3:0] beat_idx_t;

   // header word, opcode in 63:48 and start address in 47:40
   typedef struct packed {
      logic [15:0] opcode;
      mem_addr_t   addr;
      logic [39:0] reserved;
   } cmd_hdr_t;

   // beat 0 is read as hdr, every other beat as raw
   typedef union packed {
      mem_word_t raw;
      cmd_hdr_t  hdr;
   } beat_word_u;

   // write port request, 73 bits
   typedef struct packed {
      logic      en;
      mem_addr_t addr;
      mem_word_t data;
   } mem_wr_t;

endpackage

// ==== ingress_fifo.sv ====
// first-word-fall-through FIFO of stream beats
// in_ready drops while fewer than fifo_slack entries are free
// pop must only be raised while empty is low
`timescale 1ns/10ps

module ingress_fifo (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  axis_pkg::axis_beat_t in_beat,
   input  logic                 in_valid,
   output logic                 in_ready,
   input  logic                 pop,
   output axis_pkg::axis_beat_t head,
   output logic                 empty
);

   axis_pkg::axis_beat_t mem [axis_pkg::fifo_depth];

   logic [axis_pkg::fifo_addr_width-1:0] rd_ptr;
   logic [axis_pkg::fifo_addr_width-1:0] wr_ptr;
   logic [axis_pkg::fifo_addr_width:0]   count;
   logic                                 push;

   // nearly-full threshold
   assign in_ready = count <=
      (axis_pkg::fifo_addr_width + 1)'(axis_pkg::fifo_depth - axis_pkg::fifo_slack);
   assign push     = in_valid & in_ready;

   assign head  = mem[rd_ptr];   // fall-through head
   assign empty = (count == '0);

   // storage, no reset
   always_ff @(posedge axi_aclk) begin
      if (push) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps with the depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // none, or push and pop together
         endcase
      end
   end

endmodule

// ==== command_decoder.sv ====
// decodes each popped packet by beat index, no added latency
// beat 0 is the header, beats 1 to burst_len hit the buffer memory
// rd_addr holds its last value between pops so read data stays put
`timescale 1ns/10ps

module command_decoder (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  logic                  pop,
   input  axis_pkg::axis_beat_t  head,
   output logic                  subst,
   output ualink_pkg::mem_addr_t rd_addr,
   output ualink_pkg::mem_wr_t   mem_wr
);

   ualink_pkg::beat_idx_t  beat_idx;
   ualink_pkg::beat_word_u word;
   ualink_pkg::mem_addr_t  start_addr;
   ualink_pkg::mem_addr_t  burst_addr;
   ualink_pkg::mem_addr_t  rd_addr_q;
   logic                   is_wr;
   logic                   is_rd;
   logic                   in_burst;

   assign word = head.data;

   // beats 1..burst_len of the current packet
   assign in_burst = pop && (beat_idx != '0) &&
                     (beat_idx <= ualink_pkg::beat_idx_t'(ualink_pkg::burst_len));

   // start plus index minus one, wraps modulo memory depth
   assign burst_addr = start_addr + ualink_pkg::mem_addr_t'(beat_idx - 1'b1);

   always_comb begin
      mem_wr.en   = in_burst & is_wr;
      mem_wr.addr = burst_addr;
      mem_wr.data = head.data;
   end

   assign subst   = in_burst & is_rd;
   assign rd_addr = subst ? burst_addr : rd_addr_q;

   // beat counter and header capture
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         beat_idx <= '0;
         is_wr    <= 1'b0;
         is_rd    <= 1'b0;
      end else if (pop) begin
         if (beat_idx == '0) begin
            is_wr <= (word.hdr.opcode == ualink_pkg::op_write);
            is_rd <= (word.hdr.opcode == ualink_pkg::op_read);
         end
         if (head.last) begin
            beat_idx <= '0;   // next pop is a header
         end else if (beat_idx != ualink_pkg::beat_idx_t'(ualink_pkg::burst_len + 1)) begin
            beat_idx <= beat_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (pop && (beat_idx == '0)) begin
         start_addr <= word.hdr.addr;
      end
      if (subst) begin
         rd_addr_q <= burst_addr;   // keep last read address
      end
   end

endmodule

// ==== buffer_ram.sv ====
// 256 x 64 buffer memory, one write port and one registered read port
// a read and a write to the same address return the old word
`timescale 1ns/10ps

module buffer_ram (
   input  logic                  axi_aclk,
   input  ualink_pkg::mem_wr_t   wr,
   input  ualink_pkg::mem_addr_t rd_addr,
   output ualink_pkg::mem_word_t rd_data
);

   ualink_pkg::mem_word_t mem [ualink_pkg::mem_depth];

   always_ff @(posedge axi_aclk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // registered read, one cycle latency
   always_ff @(posedge axi_aclk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== egress_stage.sv ====
// one-beat output register on the master stream
// substituted beats take their data from the memory read one cycle after the pop
`timescale 1ns/10ps

module egress_stage (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  axis_pkg::axis_beat_t  head,
   input  logic                  empty,
   output logic                  pop,
   input  logic                  subst,
   input  ualink_pkg::mem_word_t rd_data,
   output axis_pkg::axis_beat_t  out_beat,
   output logic                  out_valid,
   input  logic                  out_ready
);

   axis_pkg::axis_beat_t beat_q;
   logic                 subst_q;

   // refill when the register is free or drains this cycle
   assign pop = !empty && (!out_valid || out_ready);

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         out_valid <= 1'b0;
         subst_q   <= 1'b0;
      end else if (pop) begin
         out_valid <= 1'b1;
         subst_q   <= subst;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (pop) begin
         beat_q <= head;
      end
   end

   // strb, user and last always come from the packet
   always_comb begin
      out_beat = beat_q;
      if (subst_q) begin
         out_beat.data = rd_data;
      end
   end

endmodule

// ==== ualink_turbo_top.sv ====
// packet engine top, one slave and one master AXI-Stream port
// every packet is forwarded, command packets also access the buffer memory
`timescale 1ns/10ps

module ualink_turbo_top (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,

   // slave stream
   input  axis_pkg::axis_beat_t s_axis_beat,
   input  logic                 s_axis_tvalid,
   output logic                 s_axis_tready,

   // master stream
   output axis_pkg::axis_beat_t m_axis_beat,
   output logic                 m_axis_tvalid,
   input  logic                 m_axis_tready
);

   axis_pkg::axis_beat_t  head;
   logic                  empty;
   logic                  pop;
   logic                  subst;
   ualink_pkg::mem_addr_t rd_addr;
   ualink_pkg::mem_word_t rd_data;
   ualink_pkg::mem_wr_t   mem_wr;

   ingress_fifo fifo_i (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .in_beat    (s_axis_beat),
      .in_valid   (s_axis_tvalid),
      .in_ready   (s_axis_tready),
      .pop        (pop),
      .head       (head),
      .empty      (empty)
   );

   command_decoder decoder_i (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .pop        (pop),
      .head       (head),
      .subst      (subst),
      .rd_addr    (rd_addr),
      .mem_wr     (mem_wr)
   );

   buffer_ram ram_i (
      .axi_aclk (axi_aclk),
      .wr       (mem_wr),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

   egress_stage egress_i (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .head       (head),
      .empty      (empty),
      .pop        (pop),
      .subst      (subst),
      .rd_data    (rd_data),
      .out_beat   (m_axis_beat),
      .out_valid  (m_axis_tvalid),
      .out_ready  (m_axis_tready)
   );

endmodule

// ==== tb_checker.sv ====
// scoreboard for the packet engine with memory writes modelled at input acceptance
// the model memory starts unknown, so reads only check out after a full fill
`timescale 1ns/10ps

module tb_checker (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  axis_pkg::axis_beat_t s_axis_beat,
   input  logic                 s_axis_tvalid,
   input  logic                 s_axis_tready,
   input  axis_pkg::axis_beat_t m_axis_beat,
   input  logic                 m_axis_tvalid,
   input  logic                 m_axis_tready,
   input  int                   test_num,
   input  logic                 test_end,
   input  logic                 run_end,
   input  int                   tb_fails,
   output int                   errors,
   output int                   pending
);

   ualink_pkg::mem_word_t model_mem [ualink_pkg::mem_depth];
   axis_pkg::axis_beat_t  exp_q [$];
   logic [15:0]           opcode;
   ualink_pkg::mem_addr_t start;
   logic                  was_reset = 1'b0;
   int                    in_idx    = 0;
   int                    in_beats  = 0;
   int                    out_beats = 0;
   int                    err_cnt   = 0;
   int                    in_base   = 0;
   int                    out_base  = 0;
   int                    err_base  = 0;

   // beat 0 is the header and beats 1..8 hit memory
   task automatic model_input(input axis_pkg::axis_beat_t b);
      axis_pkg::axis_beat_t  e;
      ualink_pkg::mem_addr_t a;
      e = b;
      if (in_idx == 0) begin
         opcode = b.data[63:48];
         start  = b.data[47:40];
      end else if (in_idx <= ualink_pkg::burst_len) begin
         a = start + ualink_pkg::mem_addr_t'(in_idx - 1);   // wraps mod 256
         if (opcode == ualink_pkg::op_write) begin
            model_mem[a] = b.data;
         end else if (opcode == ualink_pkg::op_read) begin
            e.data = model_mem[a];
         end
      end
      exp_q.push_back(e);
      in_beats++;
      in_idx = b.last ? 0 : in_idx + 1;
   endtask

   task automatic check_output(input axis_pkg::axis_beat_t b);
      axis_pkg::axis_beat_t e;
      if (exp_q.size() == 0) begin
         $display("output beat at %0t arrived with no input beat left to match", $time);
         err_cnt++;
      end else begin
         e = exp_q.pop_front();
         if (b !== e) begin
            $display("Mismatch at %0t: output beat %0d expected %h got %h",
                     $time, out_beats, e, b);
            err_cnt++;
         end
      end
      out_beats++;
   endtask

   always @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         in_idx    = 0;
         was_reset = 1'b1;
      end else begin
         if (was_reset) begin
            if (m_axis_tvalid !== 1'b0 || s_axis_tready !== 1'b1) begin
               $display("Mismatch at %0t: after reset tvalid %b tready %b, expected 0 and 1",
                        $time, m_axis_tvalid, s_axis_tready);
               err_cnt++;
            end
            was_reset = 1'b0;
         end
         if (s_axis_tvalid && s_axis_tready) model_input(s_axis_beat);
         if (m_axis_tvalid && m_axis_tready) check_output(m_axis_beat);
         if (test_end) begin
            $display("test %0d done: %0d beats in, %0d beats out, %0d errors", test_num,
                     in_beats - in_base, out_beats - out_base, err_cnt - err_base);
            in_base  = in_beats;
            out_base = out_beats;
            err_base = err_cnt;
         end
         if (run_end) begin
            if (in_beats != out_beats) begin
               $display("beat count differs after draining: %0d in, %0d out",
                        in_beats, out_beats);
               err_cnt++;
            end
            $display("totals: %0d tests, %0d beats in, %0d out, %0d errors, %0d other failures",
                     test_num, in_beats, out_beats, err_cnt, tb_fails);
         end
      end
      errors  <= err_cnt;      // seen by the top one edge later
      pending <= exp_q.size();
   end

endmodule

// ==== tb_top.sv ====
// testbench top for the packet engine, LCG stimulus from seed 22637
// test 1 has to run first since it fills the whole buffer memory for the read model
`timescale 1ns/10ps

module tb_top;

   localparam logic [31:0] seed        = 32'd22637;
   localparam int          wait_limit  = 2000;   // cycles per wait loop
   localparam int          test_pkts   = 40;
   localparam int          kind_raw    = 0;
   localparam int          kind_write  = 1;
   localparam int          kind_read   = 2;

   logic                 axi_aclk = 1'b0;
   logic                 axi_resetn;
   axis_pkg::axis_beat_t s_axis_beat;
   logic                 s_axis_tvalid;
   logic                 s_axis_tready;
   axis_pkg::axis_beat_t m_axis_beat;
   logic                 m_axis_tvalid;
   logic                 m_axis_tready;

   logic [31:0] stim_state = seed;
   logic [31:0] rdy_state;
   logic        hold_ready;   // forces m_axis_tready low until the input stalls
   logic        test_end;
   logic        run_end;
   logic        timed_out;
   logic        stall_seen;
   logic        recovered;
   int          test_num;
   int          fail_count;
   int          chk_errors;
   int          pending;

   always #2 axi_aclk = ~axi_aclk;

   ualink_turbo_top dut_i (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_beat   (s_axis_beat),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_beat   (m_axis_beat),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   tb_checker chk_i (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_beat   (s_axis_beat),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_beat   (m_axis_beat),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .test_num      (test_num),
      .test_end      (test_end),
      .run_end       (run_end),
      .tb_fails      (fail_count),
      .errors        (chk_errors),
      .pending       (pending)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rand32();
      stim_state = lcg_step(stim_state);
      return stim_state;
   endfunction

   // 0 .. n-1, upper bits only
   function automatic int unsigned draw(input int unsigned n);
      logic [31:0] r;
      r = rand32();
      return (r >> 8) % n;
   endfunction

   // output back-pressure, about 75% ready
   initial begin
      rdy_state     = lcg_step(seed ^ 32'h5a5a_5a5a);
      m_axis_tready = 1'b0;
      forever begin
         @(posedge axi_aclk);
         rdy_state = lcg_step(rdy_state);
         m_axis_tready <= !hold_ready && (rdy_state[31:30] != 2'b00);
      end
   end

   task automatic send_beat(input axis_pkg::axis_beat_t b);
      logic accepted;
      int   n;
      accepted = 1'b0;
      n        = 0;
      if (!timed_out) begin
         if (draw(4) == 0) begin
            repeat (1 + draw(3)) @(posedge axi_aclk);   // idle gap, valid already low
         end
         s_axis_beat   <= b;
         s_axis_tvalid <= 1'b1;
         while (!accepted && n < wait_limit) begin
            @(posedge axi_aclk);
            if (s_axis_tready) begin
               accepted = 1'b1;
            end else if (hold_ready) begin
               stall_seen = 1'b1;
               hold_ready <= 1'b0;   // let the output drain again
            end
            n++;
         end
         s_axis_tvalid <= 1'b0;
         if (accepted && stall_seen) begin
            recovered = 1'b1;
         end
         if (!accepted) begin
            $display("timeout: input beat not accepted within %0d cycles", wait_limit);
            timed_out = 1'b1;
            fail_count++;
         end
      end
   endtask

   task automatic send_packet(input int kind, input int len, input ualink_pkg::mem_addr_t addr);
      axis_pkg::axis_beat_t b;
      ualink_pkg::cmd_hdr_t h;
      for (int i = 0; i < len; i++) begin
         b.data = {rand32(), rand32()};
         b.strb = axis_pkg::strb_width'(rand32());
         b.user = axis_pkg::user_width'(rand32());
         b.last = (i == len - 1);
         if (i == 0 && kind != kind_raw) begin
            h.opcode   = (kind == kind_write) ? ualink_pkg::op_write : ualink_pkg::op_read;
            h.addr     = addr;
            h.reserved = b.data[39:0];
            b.data     = h;
         end else if (i == 0) begin
            // keep plain packets clear of both opcodes
            if (b.data[63:48] == ualink_pkg::op_write || b.data[63:48] == ualink_pkg::op_read) begin
               b.data[48] = ~b.data[48];
            end
         end
         send_beat(b);
      end
   endtask

   task automatic random_packet(input int kind, input int min_len, input int max_len);
      int                    len;
      ualink_pkg::mem_addr_t addr;
      len  = min_len + int'(draw(max_len - min_len + 1));
      addr = ualink_pkg::mem_addr_t'(draw(ualink_pkg::mem_depth));
      send_packet(kind, len, addr);
   endtask

   // drain the DUT, then let the checker print its test line
   task automatic finish_test();
      int n;
      n = 0;
      if (!timed_out) begin
         @(posedge axi_aclk);
         while (pending != 0 && n < wait_limit) begin
            @(posedge axi_aclk);
            n++;
         end
         if (pending != 0) begin
            $display("timeout: %0d output beats still missing after draining", pending);
            timed_out = 1'b1;
            fail_count++;
         end
      end
      test_end <= 1'b1;
      @(posedge axi_aclk);
      test_end <= 1'b0;
      @(posedge axi_aclk);
   endtask

   initial begin
      axi_resetn    = 1'b0;
      s_axis_beat   = '0;
      s_axis_tvalid = 1'b0;
      hold_ready    = 1'b0;
      test_end      = 1'b0;
      run_end       = 1'b0;
      timed_out     = 1'b0;
      stall_seen    = 1'b0;
      recovered     = 1'b0;
      test_num      = 0;
      fail_count    = 0;
      repeat (5) @(posedge axi_aclk);
      axi_resetn <= 1'b1;
      @(posedge axi_aclk);

      test_num = 1;   // fill all 256 words
      for (int p = 0; p < 32; p++) begin
         send_packet(kind_write, 9, ualink_pkg::mem_addr_t'(p * 8));
      end
      finish_test();

      test_num = 2;   // non-command packets
      for (int p = 0; p < test_pkts; p++) begin
         random_packet(kind_raw, 1, 12);
      end
      finish_test();

      test_num = 3;   // full writes and reads, random wrapping starts
      for (int p = 0; p < test_pkts; p++) begin
         random_packet(kind_write + int'(draw(2)), 9, 12);
      end
      finish_test();

      test_num = 4;   // short packets of every kind
      for (int p = 0; p < test_pkts; p++) begin
         random_packet(int'(draw(3)), 1, 8);
      end
      finish_test();

      test_num = 5;   // held output until the input stalls
      hold_ready <= 1'b1;
      for (int p = 0; p < test_pkts; p++) begin
         random_packet(int'(draw(3)), 1, 12);
      end
      if (!timed_out && !(stall_seen && recovered)) begin
         $display("s_axis_tready did not drop under held back-pressure or did not recover");
         fail_count++;
      end
      finish_test();

      run_end <= 1'b1;
      @(posedge axi_aclk);
      run_end <= 1'b0;
      repeat (2) @(posedge axi_aclk);
      if (fail_count == 0 && chk_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
axis_pkg.sv
ualink_pkg.sv
ingress_fifo.sv
command_decoder.sv
buffer_ram.sv
egress_stage.sv
ualink_turbo_top.sv
tb_checker.sv
tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the packet engine testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/10ps -f sources.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# verdict comes from the log
if grep -q "TESTS FAILED" "$log"; then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -q "TESTS PASSED" "$log"; then
   echo "simulation ended without a verdict"
   exit 1
fi
exit 0
